/* Makefile */
# Verilator build and run for the DMA CPU bus side testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_cpu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tb_dma_cpu.sv */
// Random testbench for the DMA CPU bus side, with memory, port and FIFO models; top is tb_dma_cpu
`timescale 1ns/1ps

module tb_dma_cpu import dma_pkg::*; ();

    localparam int FIFO_DEPTH = 8;
    localparam int NUM_LONGS  = 24;
    localparam int WAIT_LIMIT = 400;
    localparam int R_IDLE     = 0;
    localparam int R_WAIT     = 1;
    localparam int R_TERM     = 2;
    localparam int PORT_LONG  = 0;
    localparam int PORT_WORD  = 1;
    localparam int PORT_STERM = 2;

    logic              CLK90 = 1'b0;
    logic              CCRESET_;
    logic              dma_ena;
    logic              dma_dir;
    logic [ADDR_W-1:0] start_addr;
    logic              bus_grant_n;
    logic              bus_req;
    logic              bus_ack;
    logic              as;
    logic              ds;
    logic              rw;
    logic              size_word;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data_out;
    logic [DATA_W-1:0] data_in;
    logic [1:0]        dsack_n;
    logic              sterm_n;
    logic              scsi_push;
    logic [DATA_W-1:0] scsi_wdata;
    logic              scsi_pop;
    logic [DATA_W-1:0] scsi_rdata;
    logic              fifo_full;
    logic              fifo_empty;

    logic [31:0]       lfsr;
    logic [DATA_W-1:0] mem_model [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] fifo_model [$];
    logic [DATA_W-1:0] written [$];
    logic [ADDR_W-1:0] exp_addr;
    int                value_errs;
    int                proto_errs;
    int                timeout_errs;
    int                bus_cycles;
    int                longs_done;
    int                word_longs;
    int                fifo_level;
    int                level_step;
    logic              run_checks;
    logic [2:0]        ena_hist;
    logic              full_q;
    logic              empty_q;
    logic              req_q;
    logic              ack_q;
    int                grant_delay;
    int                r_state;
    int                r_wait;
    int                r_port;
    int                r_tmo;
    logic              r_lo;
    logic              half_pend;

    dma_cpu_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (.*);

    always #20 CLK90 = ~CLK90;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Unwritten locations return a pattern of the whole address
    function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a3c_c3a5;
    endfunction

    function automatic logic transfer_wanted(input logic ena, input logic full,
                                             input logic empty);
        return ena && (dma_dir ? !full : !empty);
    endfunction

    task automatic check_word(input string name, input fifo_word_u got, input fifo_word_u exp);
        if (got !== exp) begin
            value_errs++;
            $display("error %s got %h expected %h", name, got.longword, exp.longword);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_idle_outputs();
        check_flag("bus_req", bus_req, 1'b0);
        check_flag("bus_ack", bus_ack, 1'b0);
        check_flag("as", as, 1'b0);
        check_flag("ds", ds, 1'b0);
        check_flag("rw", rw, 1'b0);
        check_flag("size_word", size_word, 1'b0);
        check_flag("fifo_empty", fifo_empty, 1'b1);
        check_flag("fifo_full", fifo_full, 1'b0);
    endtask

    // Arbitration rules, checked against the transfer rule at the FSM's decision edge
    always @(posedge CLK90) begin
        if (run_checks) begin
            check_flag("as_without_bus_ack", as & ~bus_ack, 1'b0);
            check_flag("ds_without_as", ds & ~as, 1'b0);
            // FIFO flags follow the occupancy model
            check_flag("fifo_full", fifo_full, fifo_level == FIFO_DEPTH);
            check_flag("fifo_empty", fifo_empty, fifo_level == 0);
            if (bus_req && !req_q) begin
                check_flag("wanted_at_bus_req", transfer_wanted(ena_hist[2], full_q, empty_q),
                           1'b1);
            end
            if (!bus_ack && ack_q) begin
                check_flag("wanted_at_bus_ack_drop",
                           transfer_wanted(ena_hist[2], full_q, empty_q), 1'b0);
            end
        end
        ena_hist <= {ena_hist[1:0], dma_ena};
        full_q   <= (fifo_level == FIFO_DEPTH);
        empty_q  <= (fifo_level == 0);
        req_q    <= bus_req;
        ack_q    <= bus_ack;
    end

    // Arbiter grants after a random delay and releases once acknowledged
    always @(posedge CLK90) begin
        if (bus_ack || !bus_req) begin
            bus_grant_n <= 1'b1;
            grant_delay = int'(rand_bits(3));
        end else if (grant_delay == 0) begin
            bus_grant_n <= 1'b0;
        end else begin
            grant_delay--;
        end
    end

    // Drive the chosen termination and check or store write data
    task automatic terminate_cycle();
        fifo_word_u        exp_w;
        fifo_word_u        got_w;
        logic [DATA_W-1:0] word;
        logic [15:0]       noise;
        word  = mem_read(exp_addr);
        noise = 16'(rand_bits(16));
        exp_w.longword = (fifo_model.size() != 0) ? fifo_model[0] : '0;
        got_w.longword = data_out;
        if (r_port == PORT_WORD) begin
            got_w.half.lo = '0;
            if (r_lo) begin
                exp_w.half.hi = exp_w.half.lo;
            end
            exp_w.half.lo = '0;
            data_in <= {r_lo ? word[15:0] : word[31:16], noise};
            dsack_n <= 2'b01;
        end else begin
            data_in <= word;
            if (r_port == PORT_LONG) begin
                dsack_n <= 2'b00;
            end else begin
                sterm_n <= 1'b0;
            end
        end
        if (!dma_dir) begin
            check_word(r_lo ? "data_out_lo" : "data_out", got_w, exp_w);
            if (r_port != PORT_WORD) begin
                mem_model[exp_addr] = data_out;
            end else if (r_lo) begin
                mem_model[exp_addr] = {word[31:16], data_out[31:16]};
            end else begin
                mem_model[exp_addr] = {data_out[31:16], word[15:0]};
            end
        end
        r_tmo   = 0;
        r_state = R_TERM;
    endtask

    // Bookkeeping once the strobe of a terminated cycle has fallen
    task automatic finish_cycle();
        if (r_port == PORT_WORD && !r_lo) begin
            half_pend = 1'b1;
        end else begin
            if (r_lo) begin
                word_longs++;
            end
            half_pend = 1'b0;
            longs_done++;
            // The bus side steps the FIFO at this same edge
            level_step += dma_dir ? 1 : -1;
            if (dma_dir) begin
                fifo_model.push_back(mem_read(exp_addr));
            end else if (fifo_model.size() != 0) begin
                void'(fifo_model.pop_front());
            end
            exp_addr += 32'd4;
        end
    endtask

    // Memory and port model answering each address strobe
    always @(posedge CLK90) begin
        level_step = 0;
        if (!CCRESET_) begin
            r_state = R_IDLE;
        end else begin
            // SCSI side strobes step the FIFO at this edge
            if (dma_dir ? scsi_pop : scsi_push) begin
                level_step = dma_dir ? -1 : 1;
            end
            case (r_state)
                R_IDLE: begin
                    if (as) begin
                        bus_cycles++;
                        r_lo = half_pend;
                        check_flag("rw", rw, dma_dir);
                        check_flag("ds", ds, dma_dir);
                        check_flag("size_word", size_word, r_lo);
                        check_addr("addr", addr, r_lo ? exp_addr + 32'd2 : exp_addr);
                        if (!dma_dir && fifo_model.size() == 0) begin
                            proto_errs++;
                            $display("bus write cycle started with no pushed data left");
                        end
                        // A 16-bit port answers its low half as a word port too
                        r_port = r_lo ? PORT_WORD : int'(rand_bits(2) % 3);
                        r_wait = int'(rand_bits(2));
                        if (r_wait == 0) begin
                            terminate_cycle();
                        end else begin
                            r_state = R_WAIT;
                        end
                    end
                end
                R_WAIT: begin
                    if (!as) begin
                        proto_errs++;
                        $display("address strobe ended before any termination was driven");
                        r_state = R_IDLE;
                    end else begin
                        check_flag("ds", ds, 1'b1);
                        if (r_wait <= 1) begin
                            terminate_cycle();
                        end else begin
                            r_wait--;
                        end
                    end
                end
                default: begin
                    r_tmo++;
                    if (!as || r_tmo > WAIT_LIMIT) begin
                        if (as) begin
                            timeout_errs++;
                            $display("timeout waiting for the address strobe to end");
                        end
                        dsack_n <= 2'b11;
                        sterm_n <= 1'b1;
                        finish_cycle();
                        r_state = R_IDLE;
                    end
                end
            endcase
        end
        fifo_level <= fifo_level + level_step;
    end

    task automatic wait_fifo_ready(input logic want_space);
        int t;
        t = 0;
        @(posedge CLK90);
        while ((want_space ? fifo_full : fifo_empty) && t < WAIT_LIMIT) begin
            @(posedge CLK90);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            timeout_errs++;
            $display("timeout waiting for the FIFO to %s", want_space ? "have room" : "fill");
        end
    endtask

    task automatic wait_bus_idle();
        int t;
        t = 0;
        @(posedge CLK90);
        while ((bus_ack || bus_req || r_state != R_IDLE || half_pend) && t < WAIT_LIMIT) begin
            @(posedge CLK90);
            t++;
        end
        if (t >= WAIT_LIMIT) begin
            timeout_errs++;
            $display("timeout waiting for the DMA to release the bus");
        end
    endtask

    // Enable low long enough for the FSM to idle and load the start address
    task automatic setup_transfer(input logic dir, input logic [ADDR_W-1:0] base);
        @(posedge CLK90);
        dma_ena <= 1'b0;
        repeat (4) @(posedge CLK90);
        dma_dir    <= dir;
        start_addr <= base;
        repeat (4) @(posedge CLK90);
        exp_addr = base;
        dma_ena <= 1'b1;
    endtask

    task automatic pop_and_check();
        fifo_word_u exp_w;
        fifo_word_u got_w;
        got_w.longword = scsi_rdata;
        if (fifo_model.size() == 0) begin
            proto_errs++;
            $display("FIFO holds a word that no bus read delivered");
        end else begin
            exp_w.longword = fifo_model.pop_front();
            check_word("scsi_rdata", got_w, exp_w);
        end
        scsi_pop <= 1'b1;
        @(posedge CLK90);
        scsi_pop <= 1'b0;
        @(posedge CLK90);
    endtask

    task automatic finish_run();
        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errs, proto_errs, timeout_errs);
        if (value_errs + proto_errs + timeout_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        #1_000_000;
        timeout_errs++;
        $display("simulation time limit reached");
        finish_run();
    end

    initial begin
        fifo_word_u  got_w;
        fifo_word_u  exp_w;
        logic [31:0] word;
        int          popped;
        lfsr = 32'd90902;
        CCRESET_ = 1'b0;
        dma_ena = 1'b0;
        dma_dir = 1'b0;
        start_addr = '0;
        bus_grant_n = 1'b1;
        data_in = '0;
        dsack_n = 2'b11;
        sterm_n = 1'b1;
        scsi_push = 1'b0;
        scsi_wdata = '0;
        scsi_pop = 1'b0;
        value_errs = 0;
        proto_errs = 0;
        timeout_errs = 0;
        bus_cycles = 0;
        longs_done = 0;
        word_longs = 0;
        fifo_level = 0;
        level_step = 0;
        popped = 0;
        run_checks = 1'b0;
        half_pend = 1'b0;
        r_state = R_IDLE;
        exp_addr = '0;
        for (int i = 0; i < 16; i++) begin
            @(posedge CLK90);
            if (i == 15) begin
                check_idle_outputs();
            end
        end
        CCRESET_ <= 1'b1;
        repeat (4) begin
            @(posedge CLK90);
            check_idle_outputs();
        end
        run_checks = 1'b1;

        // Write direction, SCSI side pushes with random gaps
        setup_transfer(1'b0, 32'h0010_0100);
        for (int n = 0; n < NUM_LONGS; n++) begin
            repeat (int'(rand_bits(4))) @(posedge CLK90);
            wait_fifo_ready(1'b1);
            word = rand_bits(32);
            scsi_push  <= 1'b1;
            scsi_wdata <= word;
            fifo_model.push_back(word);
            written.push_back(word);
            @(posedge CLK90);
            scsi_push <= 1'b0;
            @(posedge CLK90);
        end
        wait_bus_idle();
        for (int i = 0; i < NUM_LONGS; i++) begin
            got_w.longword = mem_read(32'h0010_0100 + 32'(4 * i));
            exp_w.longword = written[i];
            check_word("memory", got_w, exp_w);
        end

        // Read direction, preloaded memory drained by random pops
        for (int i = 0; i < NUM_LONGS + FIFO_DEPTH + 4; i++) begin
            mem_model[32'h0020_0200 + 32'(4 * i)] = rand_bits(32);
        end
        setup_transfer(1'b1, 32'h0020_0200);
        for (int n = 0; n < NUM_LONGS; n++) begin
            repeat (int'(rand_bits(4))) @(posedge CLK90);
            wait_fifo_ready(1'b0);
            pop_and_check();
            popped++;
        end
        dma_ena <= 1'b0;
        repeat (4) @(posedge CLK90);
        wait_bus_idle();
        for (int i = 0; i <= FIFO_DEPTH && !fifo_empty; i++) begin
            pop_and_check();
            popped++;
        end
        if (fifo_model.size() != 0) begin
            proto_errs++;
            $display("bus reads delivered words that never left the FIFO");
        end
        if (longs_done != NUM_LONGS + popped || bus_cycles != longs_done + word_longs) begin
            proto_errs++;
            $display("bus cycle count %0d does not match %0d longwords and %0d split ones",
                     bus_cycles, longs_done, word_longs);
        end
        finish_run();
    end

endmodule

/* list.f */
rtl/dma_pkg.sv
rtl/bus_input_sync.sv
rtl/cpu_bus_sm.sv
rtl/dma_fifo.sv
rtl/cpu_data_path.sv
rtl/dma_cpu_top.sv
dv/tb_dma_cpu.sv

/* rtl/bus_input_sync.sv */
// Input stage that synchronizes grant and enable and registers and decodes bus termination
`timescale 1ns/1ps

module bus_input_sync import dma_pkg::*; (
    input  logic       CLK90,
    input  logic       CCRESET_,
    input  logic       bus_grant_n,
    input  logic       dma_ena,
    input  logic [1:0] dsack_n,
    input  logic       sterm_n,
    input  logic       as,
    output sync_in_t   sync_in,
    output bus_term_t  term
);

    logic       grant_meta;
    logic       grant_q;
    logic       ena_meta;
    logic       ena_q;
    logic [1:0] dsack_q;
    logic       sterm_q;
    logic       term_long;
    logic       term_word;

    // Two flop synchronizer, grant inverted to active high
    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            grant_meta <= 1'b0;
            grant_q    <= 1'b0;
            ena_meta   <= 1'b0;
            ena_q      <= 1'b0;
        end else begin
            grant_meta <= ~bus_grant_n;
            grant_q    <= grant_meta;
            ena_meta   <= dma_ena;
            ena_q      <= ena_meta;
        end
    end

    // Termination inputs, held released while no strobe is out
    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dsack_q <= 2'b11;
            sterm_q <= 1'b1;
        end else if (!as) begin
            dsack_q <= 2'b11;
            sterm_q <= 1'b1;
        end else begin
            dsack_q <= dsack_n;
            sterm_q <= sterm_n;
        end
    end

    // Both DSACK or STERM means a 32-bit port, DSACK1 alone a 16-bit port
    assign term_long = (dsack_q == 2'b00) || !sterm_q;
    assign term_word = (dsack_q == 2'b01);

    assign sync_in.grant  = grant_q;
    assign sync_in.enable = ena_q;

    assign term.done      = term_long | term_word;
    assign term.word_port = term_word & ~term_long;

endmodule

/* rtl/cpu_bus_sm.sv */
// Bus master FSM that arbitrates for the bus, runs strobe cycles and steps the FIFO and address
`timescale 1ns/1ps

module cpu_bus_sm import dma_pkg::*; (
    input  logic      CLK90,
    input  logic      CCRESET_,
    input  sync_in_t  sync_in,
    input  bus_term_t term,
    input  logic      dma_dir,
    input  logic      fifo_full,
    input  logic      fifo_empty,
    output sm_ctrl_t  ctrl,
    output logic      bus_req,
    output logic      bus_ack,
    output logic      as,
    output logic      ds,
    output logic      rw,
    output logic      size_word
);

    bus_state_e state;
    logic       wanted;
    logic       term_seen;

    // Read fills the FIFO, write drains it
    assign wanted = sync_in.enable && (dma_dir ? !fifo_full : !fifo_empty);

    // A termination only counts while our strobe is out
    assign term_seen = as && term.done;

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state     <= IDLE;
            bus_req   <= 1'b0;
            bus_ack   <= 1'b0;
            as        <= 1'b0;
            ds        <= 1'b0;
            rw        <= 1'b0;
            size_word <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (wanted) begin
                        bus_req <= 1'b1;
                        state   <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (!wanted) begin
                        bus_req <= 1'b0;
                        state   <= IDLE;
                    end else if (sync_in.grant) begin
                        bus_req <= 1'b0;
                        bus_ack <= 1'b1;
                        state   <= ACK;
                    end
                end
                ACK: begin
                    // Keep the bus only while there is work for it
                    if (wanted) begin
                        as    <= 1'b1;
                        ds    <= dma_dir;
                        rw    <= dma_dir;
                        state <= CYCLE_HI;
                    end else begin
                        bus_ack <= 1'b0;
                        rw      <= 1'b0;
                        state   <= IDLE;
                    end
                end
                CYCLE_HI: begin
                    if (term_seen) begin
                        as    <= 1'b0;
                        ds    <= 1'b0;
                        state <= term.word_port ? CYCLE_LO : NEXT;
                    end else if (!ds) begin
                        // Write data strobe follows one clock behind
                        ds <= 1'b1;
                    end
                end
                CYCLE_LO: begin
                    // One idle clock with as low, then the low half cycle
                    if (!as) begin
                        as        <= 1'b1;
                        ds        <= rw;
                        size_word <= 1'b1;
                    end else if (term_seen) begin
                        as        <= 1'b0;
                        ds        <= 1'b0;
                        size_word <= 1'b0;
                        state     <= NEXT;
                    end else if (!ds) begin
                        ds <= 1'b1;
                    end
                end
                NEXT: begin
                    state <= ACK;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Commands to the FIFO and data path
    always_comb begin
        ctrl = '0;
        ctrl.load_addr = (state == IDLE) && !sync_in.enable;
        ctrl.sel_lo    = (state == CYCLE_LO);
        case (state)
            CYCLE_HI: begin
                if (term_seen) begin
                    ctrl.addr_step_word = term.word_port;
                    ctrl.addr_step_long = !term.word_port;
                    ctrl.latch_hi       = dma_dir && term.word_port;
                    ctrl.latch_long     = dma_dir && !term.word_port;
                end
            end
            CYCLE_LO: begin
                if (term_seen) begin
                    ctrl.addr_step_word = 1'b1;
                    ctrl.latch_lo       = dma_dir;
                end
            end
            NEXT: begin
                // Exactly one FIFO step per longword
                ctrl.fifo_push = dma_dir;
                ctrl.fifo_pop  = !dma_dir;
            end
            default: begin
                ctrl.fifo_push = 1'b0;
            end
        endcase
    end

    a_as_needs_ack: assert property (
        @(posedge CLK90) disable iff (!CCRESET_) as |-> bus_ack
    );

    a_ds_inside_as: assert property (
        @(posedge CLK90) disable iff (!CCRESET_) ds |-> as
    );

    a_no_pop_empty: assert property (
        @(posedge CLK90) disable iff (!CCRESET_) ctrl.fifo_pop |-> !fifo_empty
    );

endmodule

/* rtl/cpu_data_path.sv */
// Address counter and data steering between the FIFO and the CPU data bus
`timescale 1ns/1ps

module cpu_data_path import dma_pkg::*; (
    input  logic              CLK90,
    input  logic              CCRESET_,
    input  sm_ctrl_t          ctrl,
    input  logic [ADDR_W-1:0] start_addr,
    input  fifo_word_u        head_word,
    input  logic [DATA_W-1:0] data_in,
    input  logic              size_word,
    output logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] data_out,
    output fifo_word_u        bus_word
);

    logic [HALF_W-1:0] out_half;
    logic [HALF_W-1:0] in_half;

    // Address carries on across bus tenures until reloaded
    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            addr <= '0;
        end else if (ctrl.load_addr) begin
            addr <= start_addr;
        end else if (ctrl.addr_step_long) begin
            addr <= addr + ADDR_W'(4);
        end else if (ctrl.addr_step_word) begin
            addr <= addr + ADDR_W'(2);
        end
    end

    // Word cycles duplicate the half on both lanes, a 16-bit port reads the upper one
    assign out_half = ctrl.sel_lo ? head_word.half.lo : head_word.half.hi;

    always_comb begin
        if (size_word) begin
            data_out = {out_half, out_half};
        end else begin
            data_out = head_word.longword;
        end
    end

    // A 16-bit port answers on the upper lanes
    assign in_half = data_in[DATA_W-1:HALF_W];

    // Incoming longword assembly
    always_ff @(posedge CLK90) begin
        if (ctrl.latch_long) begin
            bus_word.longword <= data_in;
        end else begin
            if (ctrl.latch_hi) begin
                bus_word.half.hi <= in_half;
            end
            if (ctrl.latch_lo) begin
                bus_word.half.lo <= in_half;
            end
        end
    end

endmodule

/* rtl/dma_cpu_top.sv */
// Top level of the DMA CPU bus side, wiring the input stage, FSM, FIFO and data path
`timescale 1ns/1ps

module dma_cpu_top import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              CLK90,
    input  logic              CCRESET_,
    input  logic              dma_ena,
    input  logic              dma_dir,
    input  logic [ADDR_W-1:0] start_addr,
    input  logic              bus_grant_n,
    output logic              bus_req,
    output logic              bus_ack,
    output logic              as,
    output logic              ds,
    output logic              rw,
    output logic              size_word,
    output logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] data_out,
    input  logic [DATA_W-1:0] data_in,
    input  logic [1:0]        dsack_n,
    input  logic              sterm_n,
    input  logic              scsi_push,
    input  logic [DATA_W-1:0] scsi_wdata,
    input  logic              scsi_pop,
    output logic [DATA_W-1:0] scsi_rdata,
    output logic              fifo_full,
    output logic              fifo_empty
);

    sync_in_t   sync_in;
    bus_term_t  term;
    sm_ctrl_t   ctrl;
    fifo_word_u head_word;
    fifo_word_u bus_word;

    bus_input_sync u_sync (
        .CLK90(CLK90), .CCRESET_(CCRESET_), .bus_grant_n(bus_grant_n), .dma_ena(dma_ena),
        .dsack_n(dsack_n), .sterm_n(sterm_n), .as(as), .sync_in(sync_in), .term(term)
    );

    cpu_bus_sm u_sm (
        .CLK90(CLK90), .CCRESET_(CCRESET_), .sync_in(sync_in), .term(term),
        .dma_dir(dma_dir), .fifo_full(fifo_full), .fifo_empty(fifo_empty), .ctrl(ctrl),
        .bus_req(bus_req), .bus_ack(bus_ack), .as(as), .ds(ds), .rw(rw),
        .size_word(size_word)
    );

    dma_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .CLK90(CLK90), .CCRESET_(CCRESET_), .ctrl(ctrl), .dma_dir(dma_dir),
        .bus_word(bus_word), .scsi_push(scsi_push), .scsi_wdata(scsi_wdata),
        .scsi_pop(scsi_pop), .scsi_rdata(scsi_rdata), .head_word(head_word),
        .full(fifo_full), .empty(fifo_empty)
    );

    cpu_data_path u_dp (
        .CLK90(CLK90), .CCRESET_(CCRESET_), .ctrl(ctrl), .start_addr(start_addr),
        .head_word(head_word), .data_in(data_in), .size_word(size_word), .addr(addr),
        .data_out(data_out), .bus_word(bus_word)
    );

endmodule

/* rtl/dma_fifo.sv */
// Longword FIFO between the SCSI side and the CPU bus side, direction picked by dma_dir
`timescale 1ns/1ps

module dma_fifo import dma_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              CLK90,
    input  logic              CCRESET_,
    input  sm_ctrl_t          ctrl,
    input  logic              dma_dir,
    input  fifo_word_u        bus_word,
    input  logic              scsi_push,
    input  logic [DATA_W-1:0] scsi_wdata,
    input  logic              scsi_pop,
    output logic [DATA_W-1:0] scsi_rdata,
    output fifo_word_u        head_word,
    output logic              full,
    output logic              empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    fifo_word_u       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;
    logic             do_push;
    logic             do_pop;
    fifo_word_u       wdata;

    // Read direction: bus fills, SCSI drains; write direction the other way
    assign push  = dma_dir ? ctrl.fifo_push : scsi_push;
    assign pop   = dma_dir ? scsi_pop : ctrl.fifo_pop;
    assign wdata = dma_dir ? bus_word : fifo_word_u'(scsi_wdata);

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge CLK90 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK90) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Head entry is visible to both sides without a pop
    assign head_word  = mem[rd_ptr];
    assign scsi_rdata = head_word.longword;

    a_no_push_full: assert property (
        @(posedge CLK90) disable iff (!CCRESET_) push |-> !full
    );

endmodule

/* rtl/dma_pkg.sv */
// Shared types and bus constants for the DMA CPU bus side, imported by every RTL module
package dma_pkg;

    // Bus widths fixed by the 68030 style bus
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int HALF_W = DATA_W / 2;

    // Two halves of one longword, high half on the upper lanes
    typedef struct packed {
        logic [HALF_W-1:0] hi;
        logic [HALF_W-1:0] lo;
    } half_pair_t;

    // One FIFO entry, read as a longword or as two word halves
    typedef union packed {
        logic [DATA_W-1:0] longword;
        half_pair_t        half;
    } fifo_word_u;

    // Decoded termination of the current bus cycle
    typedef struct packed {
        logic done;
        logic word_port;
    } bus_term_t;

    // Synchronized control inputs, active high
    typedef struct packed {
        logic grant;
        logic enable;
    } sync_in_t;

    // One-cycle commands from the state machine
    typedef struct packed {
        logic fifo_push;
        logic fifo_pop;
        logic load_addr;
        logic addr_step_word;
        logic addr_step_long;
        logic latch_hi;
        logic latch_lo;
        logic latch_long;
        logic sel_lo;
    } sm_ctrl_t;

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        ACK,
        CYCLE_HI,
        CYCLE_LO,
        NEXT
    } bus_state_e;

endpackage
